/* mem_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types, SDRAM command encoding and timing for the memory subsystem
// imported by every RTL block and by the behavioral SDRAM model
////////////////////////////////////////////////////////////////////////////
package mem_pkg;

    localparam int addr_w = 21;  // word address: bank 2, row 11, col 8
    localparam int data_w = 32;

    localparam int t_rcd   = 2;  // activate to read/write
    localparam int cas_lat = 2;  // read to data
    localparam int t_rp    = 2;  // precharge recovery
    localparam int t_wr    = 2;  // last write data to precharge
    localparam int t_rfc   = 7;  // auto refresh recovery
    localparam int t_mrd   = 2;  // mode register set to next command

    typedef struct packed {
        logic [1:0]  bank;
        logic [10:0] row;
        logic [7:0]  col;
    } sdram_addr_t;

    typedef struct packed {
        logic              wr;    // 1 = write
        logic              port;  // 0 = port a, 1 = port b
        sdram_addr_t       addr;
        logic [data_w-1:0] data;
        logic [3:0]        mask;  // byte enables, 1 = write byte
    } mem_req_t;

    typedef struct packed {
        logic              cs_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic [1:0]        ba;
        logic [10:0]       a;
        logic [3:0]        dqm;
        logic [data_w-1:0] dq_out;
        logic              dq_oe;
    } sdram_pins_t;

    typedef enum logic [2:0] {
        cmd_nop,
        cmd_active,
        cmd_read,
        cmd_write,
        cmd_precharge,
        cmd_refresh,
        cmd_load_mode
    } sdram_cmd_e;

    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_refresh,
        op_init
    } mem_op_e;

    // {ras_n, cas_n, we_n} for each command
    function automatic logic [2:0] encode_cmd(sdram_cmd_e cmd);
        case (cmd)
            cmd_active:    return 3'b011;
            cmd_read:      return 3'b101;
            cmd_write:     return 3'b100;
            cmd_precharge: return 3'b010;
            cmd_refresh:   return 3'b001;
            cmd_load_mode: return 3'b000;
            default:       return 3'b111;
        endcase
    endfunction

    function automatic sdram_cmd_e decode_cmd(sdram_pins_t p);
        if (p.cs_n) return cmd_nop;  // deselect
        case ({p.ras_n, p.cas_n, p.we_n})
            3'b011:  return cmd_active;
            3'b101:  return cmd_read;
            3'b100:  return cmd_write;
            3'b010:  return cmd_precharge;
            3'b001:  return cmd_refresh;
            3'b000:  return cmd_load_mode;
            default: return cmd_nop;  // burst stop also treated as nop
        endcase
    endfunction

endpackage

/* wb_req_port.sv */
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave front end; one bus cycle becomes one request
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_req_port import mem_pkg::*; #(
    parameter bit has_write = 1'b1,
    parameter bit port_id   = 1'b0
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    input  logic [3:0]        sel,
    input  logic              rsp_valid,
    input  logic [data_w-1:0] rsp_data,
    output logic              ack,
    output logic [data_w-1:0] dat_r,
    output logic              push,
    output mem_req_t          req,
    input  logic              full
);

    logic waiting;  // request queued, response not yet back

    // ack cycle still shows stb from the master, so no push then
    assign push = cyc && stb && !waiting && !ack && !full;

    always_comb begin
        req.wr   = has_write ? we : 1'b0;
        req.port = port_id;
        req.addr = adr;
        req.data = has_write ? dat_w : '0;
        req.mask = has_write ? sel : 4'hf;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            waiting <= 1'b0;
            ack     <= 1'b0;
        end else begin
            ack <= rsp_valid;  // one cycle after the response
            if (rsp_valid) begin
                waiting <= 1'b0;
            end else if (push) begin
                waiting <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            dat_r <= rsp_data;
        end
    end

    // ack must close a request that this port actually queued
    a_ack_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        ack |-> $past(waiting));

    // read-only port never sees a write cycle from its master
    a_no_write: assert property (@(posedge clk) disable iff (!resetn)
        (!has_write && cyc && stb) |-> !we);

endmodule

/* req_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// small synchronous request FIFO between a host port and the sequencer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module req_fifo import mem_pkg::*; #(
    parameter int depth = 4
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     push,
    input  mem_req_t din,
    input  logic     pop,
    output mem_req_t dout,
    output logic     full,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    mem_req_t             mem [depth];
    logic     [ptr_w-1:0] wr_ptr;
    logic     [ptr_w-1:0] rd_ptr;
    logic     [cnt_w-1:0] count;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // head, valid while not empty

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        pop |-> !empty);

endmodule

/* mem_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// init gating, refresh timing and fixed-priority arbitration of both ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_sequencer import mem_pkg::*; #(
    parameter int init_cycles      = 200,
    parameter int refresh_interval = 390
) (
    input  logic              clk,
    input  logic              resetn,
    input  mem_req_t          a_head,
    input  logic              a_empty,
    input  mem_req_t          b_head,
    input  logic              b_empty,
    output logic              a_pop,
    output logic              b_pop,
    output logic              start,
    output mem_op_e           op,
    output mem_req_t          req,
    input  logic              busy,
    input  logic              done,
    input  logic [data_w-1:0] rd_data,
    output logic              a_rsp_valid,
    output logic              b_rsp_valid,
    output logic [data_w-1:0] rsp_data
);

    localparam int pwr_w = $clog2(init_cycles + 1);
    localparam int ref_w = $clog2(refresh_interval + 1);

    typedef enum logic [2:0] {
        st_wait_power,
        st_init,
        st_idle,
        st_access,
        st_refresh
    } state_e;

    state_e             state;
    logic   [pwr_w-1:0] pwr_cnt;
    logic   [ref_w-1:0] ref_cnt;
    logic               ref_pend;
    logic               cur_port;  // port of the access in flight

    logic idle_go;

    // idle is only entered after done, so the command block is free here
    assign idle_go = (state == st_idle);

    always_comb begin
        a_pop = 1'b0;
        b_pop = 1'b0;
        start = 1'b0;
        op    = op_init;
        req   = a_head;
        if (state == st_wait_power && pwr_cnt == '0) begin
            start = 1'b1;
        end else if (idle_go) begin
            if (ref_pend) begin  // refresh beats both ports
                start = 1'b1;
                op    = op_refresh;
            end else if (!a_empty) begin
                start = 1'b1;
                a_pop = 1'b1;
                op    = a_head.wr ? op_write : op_read;
            end else if (!b_empty) begin
                start = 1'b1;
                b_pop = 1'b1;
                op    = b_head.wr ? op_write : op_read;
                req   = b_head;
            end
        end
    end

    // done of an access goes back to the port that asked
    assign a_rsp_valid = (state == st_access) && done && !cur_port;
    assign b_rsp_valid = (state == st_access) && done && cur_port;
    assign rsp_data    = rd_data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= st_wait_power;
            pwr_cnt  <= pwr_w'(init_cycles);
            ref_cnt  <= ref_w'(refresh_interval - 1);
            ref_pend <= 1'b0;
            cur_port <= 1'b0;
        end else begin
            if (ref_cnt == '0) begin
                ref_cnt  <= ref_w'(refresh_interval - 1);
                ref_pend <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt - 1'b1;
            end

            case (state)
                st_wait_power: begin
                    if (pwr_cnt == '0) state <= st_init;
                    else pwr_cnt <= pwr_cnt - 1'b1;
                end
                st_init, st_refresh: begin
                    if (done) state <= st_idle;
                end
                st_idle: begin
                    if (start && op == op_refresh) begin
                        state    <= st_refresh;
                        ref_pend <= 1'b0;  // an expiry in this same cycle is dropped
                    end else if (start) begin
                        state    <= st_access;
                        cur_port <= req.port;
                    end
                end
                st_access: begin
                    if (done) state <= st_idle;
                end
                default: state <= st_wait_power;
            endcase
        end
    end

    // the init start is the only one issued before the command block is ready
    a_start_not_busy: assert property (@(posedge clk) disable iff (!resetn)
        start |-> (!busy || op == op_init));

endmodule

/* sdram_cmd.sv */
////////////////////////////////////////////////////////////////////////////
// SDRAM command generator; closed-page access, refresh and init sequences
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sdram_cmd import mem_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  mem_op_e           op,
    input  mem_req_t          req,
    output logic              busy,
    output logic              done,
    output logic [data_w-1:0] rd_data,
    output sdram_pins_t       pins,
    input  logic [data_w-1:0] dq_in
);

    localparam int step_w = 5;

    // steps counted from the cycle after start
    localparam logic [step_w-1:0] act_step     = 1;
    localparam logic [step_w-1:0] rw_step      = step_w'(1 + t_rcd);
    localparam logic [step_w-1:0] rd_data_step = step_w'(1 + t_rcd + cas_lat);
    localparam logic [step_w-1:0] rd_pre_step  = step_w'(2 + t_rcd + cas_lat);
    localparam logic [step_w-1:0] rd_done_step = step_w'(2 + t_rcd + cas_lat + t_rp);
    localparam logic [step_w-1:0] wr_pre_step  = step_w'(1 + t_rcd + t_wr);
    localparam logic [step_w-1:0] wr_done_step = step_w'(1 + t_rcd + t_wr + t_rp);
    localparam logic [step_w-1:0] rf_done_step = step_w'(1 + t_rfc);
    localparam logic [step_w-1:0] in_ref1_step = step_w'(1 + t_rp);
    localparam logic [step_w-1:0] in_ref2_step = step_w'(1 + t_rp + t_rfc);
    localparam logic [step_w-1:0] in_lmr_step  = step_w'(1 + t_rp + 2 * t_rfc);
    localparam logic [step_w-1:0] in_done_step = step_w'(1 + t_rp + 2 * t_rfc + t_mrd);

    localparam logic [10:0] mode_word = 11'h020;  // burst 1, cas latency 2

    logic                running;
    logic                init_done;
    logic [step_w-1:0]   step;
    logic [step_w-1:0]   last_step;
    mem_op_e             cur_op;
    mem_req_t            lat_req;
    sdram_cmd_e          cmd;

    assign busy = running || !init_done;  // stays high until init has run
    assign done = running && (step == last_step);

    always_comb begin
        case (cur_op)
            op_read:    last_step = rd_done_step;
            op_write:   last_step = wr_done_step;
            op_refresh: last_step = rf_done_step;
            default:    last_step = in_done_step;
        endcase
    end

    always_comb begin
        cmd = cmd_nop;
        if (running) begin
            case (cur_op)
                op_read: begin
                    if (step == act_step) cmd = cmd_active;
                    else if (step == rw_step) cmd = cmd_read;
                    else if (step == rd_pre_step) cmd = cmd_precharge;
                end
                op_write: begin
                    if (step == act_step) cmd = cmd_active;
                    else if (step == rw_step) cmd = cmd_write;
                    else if (step == wr_pre_step) cmd = cmd_precharge;
                end
                op_refresh: begin
                    if (step == act_step) cmd = cmd_refresh;
                end
                default: begin
                    if (step == act_step) cmd = cmd_precharge;
                    else if (step == in_ref1_step) cmd = cmd_refresh;
                    else if (step == in_ref2_step) cmd = cmd_refresh;
                    else if (step == in_lmr_step) cmd = cmd_load_mode;
                end
            endcase
        end
    end

    always_comb begin
        pins.cs_n = 1'b0;
        {pins.ras_n, pins.cas_n, pins.we_n} = encode_cmd(cmd);
        pins.ba = 2'b00;
        pins.a  = 11'h000;
        case (cmd)
            cmd_active: begin
                pins.ba = lat_req.addr.bank;
                pins.a  = lat_req.addr.row;
            end
            cmd_read, cmd_write: begin
                pins.ba = lat_req.addr.bank;
                pins.a  = {3'b000, lat_req.addr.col};  // a10 low, no auto precharge
            end
            cmd_precharge: pins.a = 11'h400;  // all banks
            cmd_load_mode: pins.a = mode_word;
            default:       pins.a = 11'h000;
        endcase
        pins.dqm    = (cmd == cmd_write) ? ~lat_req.mask : 4'h0;
        pins.dq_out = lat_req.data;
        pins.dq_oe  = (cmd == cmd_write);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running   <= 1'b0;
            init_done <= 1'b0;
            step      <= '0;
            cur_op    <= op_init;
        end else if (start && !running && (init_done || op == op_init)) begin
            running <= 1'b1;
            step    <= act_step;
            cur_op  <= op;
        end else if (done) begin
            running <= 1'b0;
            if (cur_op == op_init) init_done <= 1'b1;
        end else if (running) begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running) begin
            lat_req <= req;
        end
        if (running && cur_op == op_read && step == rd_data_step) begin
            rd_data <= dq_in;  // cas_lat after the read
        end
    end

    a_rp_quiet: assert property (@(posedge clk) disable iff (!resetn)
        decode_cmd(pins) == cmd_precharge |=> (decode_cmd(pins) == cmd_nop) [*t_rp-1]);

    a_rfc_quiet: assert property (@(posedge clk) disable iff (!resetn)
        decode_cmd(pins) == cmd_refresh |=> (decode_cmd(pins) == cmd_nop) [*t_rfc-1]);

endmodule

/* mem_subsys_top.sv */
////////////////////////////////////////////////////////////////////////////
// SDRAM subsystem top; read/write port a and read-only port b over Wishbone
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; #(
    parameter int init_cycles      = 200,
    parameter int refresh_interval = 390,
    parameter int fifo_depth       = 4
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              a_cyc,
    input  logic              a_stb,
    input  logic              a_we,
    input  logic [addr_w-1:0] a_adr,
    input  logic [data_w-1:0] a_dat_w,
    input  logic [3:0]        a_sel,
    output logic [data_w-1:0] a_dat_r,
    output logic              a_ack,
    input  logic              b_cyc,
    input  logic              b_stb,
    input  logic [addr_w-1:0] b_adr,
    output logic [data_w-1:0] b_dat_r,
    output logic              b_ack,
    output sdram_pins_t       sdram,
    input  logic [data_w-1:0] sdram_dq_in
);

    mem_req_t          a_req, b_req, a_head, b_head, cmd_req;
    logic              a_push, b_push, a_full, b_full, a_empty, b_empty;
    logic              a_pop, b_pop, a_rsp_valid, b_rsp_valid;
    logic              start, busy, done;
    mem_op_e           op;
    logic [data_w-1:0] rd_data, rsp_data;

    wb_req_port #(.has_write(1'b1), .port_id(1'b0)) i_port_a (
        .clk(clk), .resetn(resetn), .cyc(a_cyc), .stb(a_stb), .we(a_we),
        .adr(a_adr), .dat_w(a_dat_w), .sel(a_sel),
        .rsp_valid(a_rsp_valid), .rsp_data(rsp_data), .ack(a_ack), .dat_r(a_dat_r),
        .push(a_push), .req(a_req), .full(a_full)
    );

    // read-only port, write inputs tied off
    wb_req_port #(.has_write(1'b0), .port_id(1'b1)) i_port_b (
        .clk(clk), .resetn(resetn), .cyc(b_cyc), .stb(b_stb), .we(1'b0),
        .adr(b_adr), .dat_w('0), .sel(4'hf),
        .rsp_valid(b_rsp_valid), .rsp_data(rsp_data), .ack(b_ack), .dat_r(b_dat_r),
        .push(b_push), .req(b_req), .full(b_full)
    );

    req_fifo #(.depth(fifo_depth)) i_fifo_a (
        .clk(clk), .resetn(resetn), .push(a_push), .din(a_req), .pop(a_pop),
        .dout(a_head), .full(a_full), .empty(a_empty)
    );

    req_fifo #(.depth(fifo_depth)) i_fifo_b (
        .clk(clk), .resetn(resetn), .push(b_push), .din(b_req), .pop(b_pop),
        .dout(b_head), .full(b_full), .empty(b_empty)
    );

    mem_sequencer #(
        .init_cycles(init_cycles),
        .refresh_interval(refresh_interval)
    ) i_seq (
        .clk(clk), .resetn(resetn),
        .a_head(a_head), .a_empty(a_empty), .b_head(b_head), .b_empty(b_empty),
        .a_pop(a_pop), .b_pop(b_pop), .start(start), .op(op), .req(cmd_req),
        .busy(busy), .done(done), .rd_data(rd_data),
        .a_rsp_valid(a_rsp_valid), .b_rsp_valid(b_rsp_valid), .rsp_data(rsp_data)
    );

    sdram_cmd i_cmd (
        .clk(clk), .resetn(resetn), .start(start), .op(op), .req(cmd_req),
        .busy(busy), .done(done), .rd_data(rd_data),
        .pins(sdram), .dq_in(sdram_dq_in)
    );

endmodule

/* sdram_model.sv */
////////////////////////////////////////////////////////////////////////////
// behavioral SDRAM for the testbench; stores words, checks command order
// error flags and the refresh count are read hierarchically by the tb
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sdram_model import mem_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  sdram_pins_t       pins,
    output logic [data_w-1:0] dq_in
);

    logic [data_w-1:0] mem [1024];
    logic [data_w-1:0] rd_pipe [cas_lat];
    sdram_cmd_e        cmd;
    logic              row_open;
    logic [1:0]        open_bank;
    logic [10:0]       open_row;
    logic              mode_set;     // load mode seen, init finished
    int                quiet;        // cycles left in a recovery window
    int                act_age;      // cycles since the last activate
    int                ref_count;    // refreshes after the mode load
    logic              timing_err;
    logic              ref_row_err;
    logic              init_err;
    logic              proto_err;

    assign cmd   = decode_cmd(pins);
    assign dq_in = rd_pipe[cas_lat-1];

    // 1024 words, so bank, low row bits and low column bits pick the slot
    function automatic logic [9:0] fold(logic [1:0] ba, logic [10:0] row, logic [7:0] col);
        return {ba, row[1:0], col[5:0]};
    endfunction

    always_ff @(posedge clk) begin
        logic [9:0] idx;
        idx = fold(pins.ba, open_row, pins.a[7:0]);
        if (!resetn) begin
            row_open    <= 1'b0;
            open_bank   <= 2'b00;
            open_row    <= 11'h000;
            mode_set    <= 1'b0;
            quiet       <= 0;
            act_age     <= 0;
            ref_count   <= 0;
            timing_err  <= 1'b0;
            ref_row_err <= 1'b0;
            init_err    <= 1'b0;
            proto_err   <= 1'b0;
            for (int i = 0; i < cas_lat; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            rd_pipe[0] <= (cmd == cmd_read) ? mem[idx] : '0;
            for (int i = 1; i < cas_lat; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
            if (quiet > 0) quiet <= quiet - 1;
            if (act_age < 1000) act_age <= act_age + 1;
            if (cmd != cmd_nop && quiet > 0) timing_err <= 1'b1;  // inside t_rp / t_rfc
            case (cmd)
                cmd_active: begin
                    if (!mode_set) init_err <= 1'b1;
                    if (row_open) proto_err <= 1'b1;
                    row_open  <= 1'b1;
                    open_bank <= pins.ba;
                    open_row  <= pins.a;
                    act_age   <= 1;
                end
                cmd_read, cmd_write: begin
                    if (!row_open || pins.ba != open_bank) proto_err <= 1'b1;
                    if (act_age < t_rcd) timing_err <= 1'b1;
                    if (cmd == cmd_write) begin
                        if (!pins.dq_oe) proto_err <= 1'b1;
                        for (int b = 0; b < 4; b++) begin
                            if (!pins.dqm[b]) mem[idx][8*b +: 8] <= pins.dq_out[8*b +: 8];
                        end
                    end
                end
                cmd_precharge: begin
                    row_open <= 1'b0;  // all banks
                    quiet    <= t_rp - 1;
                end
                cmd_refresh: begin
                    if (row_open) ref_row_err <= 1'b1;
                    if (mode_set) ref_count <= ref_count + 1;
                    quiet <= t_rfc - 1;
                end
                cmd_load_mode: begin
                    if (row_open) proto_err <= 1'b1;
                    mode_set <= 1'b1;
                    quiet    <= t_mrd - 1;
                end
                default: ;
            endcase
        end
    end

endmodule

/* tb_mem_subsys.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the SDRAM subsystem; runs a table of port a and b accesses
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int init_cycles      = 200;
    localparam int refresh_interval = 390;

    typedef struct packed {
        logic              port;       // 0 = a, 1 = b
        logic              wr;
        logic              with_next;  // starts together with the next entry
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [3:0]        sel;
        logic [data_w-1:0] exp;
    } entry_t;

    logic              clk;
    logic              resetn;
    logic              a_cyc;
    logic              a_stb;
    logic              a_we;
    logic [addr_w-1:0] a_adr;
    logic [data_w-1:0] a_dat_w;
    logic [3:0]        a_sel;
    logic [data_w-1:0] a_dat_r;
    logic              a_ack;
    logic              b_cyc;
    logic              b_stb;
    logic [addr_w-1:0] b_adr;
    logic [data_w-1:0] b_dat_r;
    logic              b_ack;
    sdram_pins_t       sdram;
    logic [data_w-1:0] sdram_dq_in;

    entry_t            stim_q[$];
    logic [data_w-1:0] shadow [logic [addr_w-1:0]];  // expected memory contents
    logic [data_w-1:0] rnd [8];
    logic [addr_w-1:0] adr_set [4];
    integer            seed = 88;
    int                cycle_cnt = 0;
    int                init_cycle = -1;
    int                limit = init_cycles + 2000;

    mem_subsys_top #(
        .init_cycles(init_cycles),
        .refresh_interval(refresh_interval),
        .fifo_depth(4)
    ) i_mem_subsys_top (
        .clk(clk), .resetn(resetn),
        .a_cyc(a_cyc), .a_stb(a_stb), .a_we(a_we), .a_adr(a_adr), .a_dat_w(a_dat_w),
        .a_sel(a_sel), .a_dat_r(a_dat_r), .a_ack(a_ack),
        .b_cyc(b_cyc), .b_stb(b_stb), .b_adr(b_adr), .b_dat_r(b_dat_r), .b_ack(b_ack),
        .sdram(sdram), .sdram_dq_in(sdram_dq_in)
    );

    sdram_model i_model (.clk(clk), .resetn(resetn), .pins(sdram), .dq_in(sdram_dq_in));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (init_cycle < 0 && i_model.mode_set) init_cycle <= cycle_cnt;
        if (cycle_cnt >= limit) abort_run($sformatf("run exceeded %0d cycles", limit));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        assert (got === exp)
        else abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic expect_true(input string what, input logic ok);
        assert (ok === 1'b1)
        else abort_run(what);
    endtask

    function automatic logic [addr_w-1:0] make_addr(int bank, int row, int col);
        return {bank[1:0], row[10:0], col[7:0]};
    endfunction

    // appends one access; reads take the merged bytes of all earlier writes
    task automatic add_entry(input logic port, input logic wr, input logic with_next,
                             input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             input logic [3:0] sel);
        entry_t            e;
        logic [data_w-1:0] word;
        word = shadow.exists(addr) ? shadow[addr] : '0;
        e.port      = port;
        e.wr        = wr;
        e.with_next = with_next;
        e.addr      = addr;
        e.data      = data;
        e.sel       = sel;
        e.exp       = word;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) word[8*b +: 8] = data[8*b +: 8];
            end
            shadow[addr] = word;
            e.exp        = '0;
        end
        stim_q.push_back(e);
    endtask

    task automatic drive_port(input entry_t e);
        if (!e.port) begin
            a_cyc   = 1'b1;
            a_stb   = 1'b1;
            a_we    = e.wr;
            a_adr   = e.addr;
            a_dat_w = e.data;
            a_sel   = e.sel;
        end else begin
            b_cyc = 1'b1;
            b_stb = 1'b1;
            b_adr = e.addr;
        end
    endtask

    // starts one or two entries in the same cycle and waits for every ack
    task automatic run_group(input int first, input int count);
        entry_t ea;
        entry_t eb;
        logic   wait_a;
        logic   wait_b;
        ea     = '0;
        eb     = '0;
        wait_a = 1'b0;
        wait_b = 1'b0;
        @(posedge clk);
        #10;
        for (int k = first; k < first + count; k++) begin
            drive_port(stim_q[k]);
            if (stim_q[k].port) begin
                eb     = stim_q[k];
                wait_b = 1'b1;
            end else begin
                ea     = stim_q[k];
                wait_a = 1'b1;
            end
        end
        while (wait_a || wait_b) begin
            @(posedge clk);
            #10;
            if (wait_a && a_ack) begin
                expect_true("port a acked before SDRAM init finished", i_model.mode_set);
                if (!ea.wr) check_word("a_dat_r", a_dat_r, ea.exp);
                a_cyc  = 1'b0;
                a_stb  = 1'b0;
                a_we   = 1'b0;
                wait_a = 1'b0;
            end
            if (wait_b && b_ack) begin
                expect_true("port b acked before SDRAM init finished", i_model.mode_set);
                check_word("b_dat_r", b_dat_r, eb.exp);
                b_cyc  = 1'b0;
                b_stb  = 1'b0;
                wait_b = 1'b0;
            end
        end
    endtask

    initial begin
        int idx;
        int n;
        int min_ref;
        resetn  = 1'b0;
        a_cyc   = 1'b0;
        a_stb   = 1'b0;
        a_we    = 1'b0;
        a_adr   = '0;
        a_dat_w = '0;
        a_sel   = 4'h0;
        b_cyc   = 1'b0;
        b_stb   = 1'b0;
        b_adr   = '0;
        for (int i = 0; i < 8; i++) begin
            rnd[i] = $random(seed);
        end
        adr_set[0] = make_addr(0, 1, 8'h04);  // different banks and rows
        adr_set[1] = make_addr(1, 2, 8'h10);
        adr_set[2] = make_addr(2, 3, 8'h21);
        adr_set[3] = make_addr(3, 0, 8'h3f);

        add_entry(1'b0, 1'b1, 1'b0, adr_set[0], rnd[0], 4'hf);  // waits for init
        add_entry(1'b0, 1'b0, 1'b0, adr_set[0], '0, 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, adr_set[1], rnd[1], 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, adr_set[2], rnd[2], 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, adr_set[1], '0, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, adr_set[2], '0, 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, adr_set[3], rnd[3], 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, adr_set[3], rnd[4], 4'b0101);  // partial write
        add_entry(1'b0, 1'b0, 1'b0, adr_set[3], '0, 4'hf);
        add_entry(1'b1, 1'b0, 1'b0, adr_set[0], '0, 4'hf);
        add_entry(1'b0, 1'b1, 1'b0, adr_set[0], rnd[5], 4'b1010);
        add_entry(1'b1, 1'b0, 1'b0, adr_set[1], '0, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, adr_set[0], '0, 4'hf);
        add_entry(1'b1, 1'b0, 1'b0, adr_set[3], '0, 4'hf);
        add_entry(1'b0, 1'b0, 1'b1, adr_set[2], '0, 4'hf);  // both ports at once
        add_entry(1'b1, 1'b0, 1'b0, adr_set[0], '0, 4'hf);
        add_entry(1'b0, 1'b1, 1'b1, adr_set[1], rnd[6], 4'b0011);
        add_entry(1'b1, 1'b0, 1'b0, adr_set[2], '0, 4'hf);
        add_entry(1'b0, 1'b0, 1'b0, adr_set[1], '0, 4'hf);
        limit = init_cycles + 40 * stim_q.size() + 2000;

        repeat (16) @(posedge clk);
        #10;
        resetn = 1'b1;

        idx = 0;
        while (idx < stim_q.size()) begin
            n = stim_q[idx].with_next ? 2 : 1;
            run_group(idx, n);
            idx += n;
        end
        repeat (1200) @(posedge clk);  // idle time for periodic refreshes

        expect_true("SDRAM init never loaded the mode register", init_cycle >= 0);
        expect_true("ACTIVATE issued before init finished", !i_model.init_err);
        expect_true("command issued inside a recovery window", !i_model.timing_err);
        expect_true("refresh issued with a row open", !i_model.ref_row_err);
        expect_true("access to a closed row or missing write data", !i_model.proto_err);
        min_ref = (cycle_cnt - init_cycle) / refresh_interval - 1;
        assert (i_model.ref_count >= min_ref)
        else abort_run($sformatf("only %0d refreshes seen, at least %0d needed",
                                 i_model.ref_count, min_ref));
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* vlog.f */
mem_pkg.sv
wb_req_port.sv
req_fifo.sv
mem_sequencer.sv
sdram_cmd.sv
mem_subsys_top.sv
sdram_model.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsys
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
